// File: build.f
hw/player_pkg.sv
hw/key_decode.sv
hw/rate_gen.sv
hw/flash_reader.sv
hw/sample_out.sv
hw/audio_player_top.sv
dv/player_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the player testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f build.f --top-module player_tb -o player_sim

out=$(./obj_dir/player_sim)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$"

// File: dv/player_tb.sv
`timescale 1ns/1ps

module player_tb import player_pkg::*; ();

  // Planned work, used for the cycle limit
  localparam int PLAN_WORDS   = 34 + 12 * 4;
  localparam int PLAN_PAUSES  = 19;
  localparam int PLAN_SAMPLES = 2 * (PLAN_WORDS + PLAN_PAUSES);
  localparam int MAX_P        = int'(RATE_MAX);
  localparam int LIMIT        = PLAN_SAMPLES * (2 * MAX_P + 20)
                              + PLAN_PAUSES * (6 * MAX_P + 2000) + 1000;

  logic              clk;
  logic              rst;
  logic              key_valid;
  logic [7:0]        key_code;
  logic              speed_up;
  logic              speed_down;
  logic              speed_reset;
  logic              flash_waitrequest;
  logic [WORD_W-1:0] flash_readdata;
  logic              flash_readdatavalid;
  flash_req_t        flash_req;
  logic [7:0]        sample;
  logic              sample_valid;

  audio_player_top uut (
    .clk, .rst, .key_valid, .key_code,
    .speed_up, .speed_down, .speed_reset,
    .flash_waitrequest, .flash_readdata, .flash_readdatavalid,
    .flash_req, .sample, .sample_valid
  );

  // Reference model state
  logic              m_dir;
  int                m_period;
  logic [ADDR_W-1:0] exp_addr;
  logic              cur_dir;     // Direction of word in flight
  logic [WORD_W-1:0] cur_word;
  logic              byte_idx;
  logic [7:0]        exp_byte;
  int                samples_seen;
  int                cycle;
  int                last_cycle;
  bit                have_last;
  bit                timing_on;
  bit                quiet;
  logic [31:0]       rng;
  logic [31:0]       frng;         // Flash model stream
  int                wait_cnt;
  int                data_cnt;
  logic [WORD_W-1:0] pend_word;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Fixed content of flash, mixed from the full address
  function automatic logic [WORD_W-1:0] addr_hash(input logic [ADDR_W-1:0] a);
    return xorshift(xorshift({9'h0, a} ^ 32'h5bd1_e995));
  endfunction

  // Region is 2^19 words, so step modulo that
  function automatic logic [ADDR_W-1:0] next_addr(input logic [ADDR_W-1:0] a,
                                                  input logic back);
    logic [18:0] low;
    low = a[18:0] + (back ? 19'h7FFFF : 19'h1);
    return {4'h0, low};
  endfunction

  function automatic int next_period(input int p, input logic up, input logic dn,
                                     input logic rs);
    int n;
    n = p;
    if (rs) n = int'(RATE_DEFAULT);
    else if (up) n = p - int'(RATE_STEP);
    else if (dn) n = p + int'(RATE_STEP);
    if (n < int'(RATE_MIN)) n = int'(RATE_MIN);
    if (n > MAX_P) n = MAX_P;
    return n;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch at %0t: %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
    end
  endtask

  // ========================================
  // Clock and flash model
  // ========================================
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      flash_waitrequest   <= 1'b0;
      flash_readdatavalid <= 1'b0;
      wait_cnt = 0;
      data_cnt = 0;
    end else begin
      flash_readdatavalid <= 1'b0;
      if (data_cnt != 0) begin
        data_cnt--;
        if (data_cnt == 0) begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= pend_word;
        end
      end
      if (flash_req.read && !flash_waitrequest) begin  // Accepted
        pend_word = addr_hash(flash_req.addr);
        frng      = xorshift(frng);
        data_cnt  = 1 + int'(frng % 6);
        frng      = xorshift(frng);
        wait_cnt  = int'(frng % 4);  // Stall for the next read
        flash_waitrequest <= (wait_cnt != 0);
      end else if (flash_req.read && flash_waitrequest) begin
        wait_cnt--;
        if (wait_cnt == 0) flash_waitrequest <= 1'b0;
      end
    end
  end

  // ========================================
  // Watchdog and monitor against the model
  // ========================================
  always @(posedge clk) begin
    cycle++;
    if (cycle >= LIMIT) stop_with_error("Timeout: playback stalled before the tests finished");
    if (!rst) begin
      if (quiet && (flash_req.read || sample_valid))
        stop_with_error("Read or sample seen while playback was paused");
      if (flash_req.read && !flash_waitrequest) begin
        check("flash_req.addr", 32'(flash_req.addr), 32'(exp_addr));
        cur_dir  = m_dir;
        cur_word = addr_hash(exp_addr);
        byte_idx = 1'b0;
      end
      if (sample_valid) begin
        // Byte 0 is 15:8 forward and 31:24 backward
        if (!byte_idx) exp_byte = cur_dir ? cur_word[31:24] : cur_word[15:8];
        else           exp_byte = cur_dir ? cur_word[15:8] : cur_word[31:24];
        check("sample", 32'(sample), 32'(exp_byte));
        if (timing_on && have_last) check("sample interval", cycle - last_cycle, m_period);
        last_cycle = cycle;
        have_last  = 1'b1;
        if (byte_idx) exp_addr = next_addr(exp_addr, cur_dir);  // Word done
        byte_idx = ~byte_idx;
        samples_seen++;
      end
    end
  end

  // ========================================
  // Stimulus tasks
  // ========================================
  task automatic send_key(input logic [7:0] code);
    @(posedge clk);
    key_valid <= 1'b1;
    key_code  <= code;
    @(posedge clk);
    key_valid <= 1'b0;
    case (code)
      KEY_FWD:     m_dir = 1'b0;
      KEY_BACK:    m_dir = 1'b1;
      KEY_RESTART: exp_addr = m_dir ? ADDR_LAST : '0;  // Applied at once while paused
      default: ;
    endcase
    repeat (3) @(posedge clk);
  endtask

  task automatic send_speed(input logic up, input logic dn, input logic rs);
    @(posedge clk);
    speed_up    <= up;
    speed_down  <= dn;
    speed_reset <= rs;
    @(posedge clk);
    speed_up    <= 1'b0;
    speed_down  <= 1'b0;
    speed_reset <= 1'b0;
    m_period = next_period(m_period, up, dn, rs);
  endtask

  // Lets the divider reload with the new period
  task automatic settle_rate();
    repeat (MAX_P + 10) @(posedge clk);
  endtask

  task automatic play_words(input int n);
    int target;
    target    = samples_seen + 2 * n;
    have_last = 1'b0;
    timing_on = 1'b1;
    send_key(KEY_PLAY);
    while (samples_seen < target) @(posedge clk);
  endtask

  task automatic pause_playback();
    int start;
    start     = samples_seen;
    timing_on = 1'b0;
    send_key(KEY_PAUSE);
    repeat (2 * m_period + 60) @(posedge clk);
    if (samples_seen - start > 2)
      stop_with_error("More than the word in flight played after pause");
    quiet = 1'b1;
    repeat (3 * MAX_P) @(posedge clk);
    quiet = 1'b0;
  endtask

  function automatic logic [7:0] random_code(input logic [31:0] r);
    logic [7:0] c;
    case (r % 6)
      0: c = KEY_FWD;
      1: c = KEY_BACK;
      2: c = KEY_RESTART;
      3: c = KEY_PAUSE;
      default: begin
        c = r[15:8];  // Non-command byte
        if (c inside {KEY_PLAY, KEY_PAUSE, KEY_FWD, KEY_BACK, KEY_RESTART}) c = 8'h20;
      end
    endcase
    return c;
  endfunction

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    rst = 1'b1;
    key_valid = 1'b0;
    key_code = 8'h00;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_reset = 1'b0;
    flash_waitrequest = 1'b0;
    flash_readdata = '0;
    flash_readdatavalid = 1'b0;
    m_dir = 1'b0;
    m_period = int'(RATE_DEFAULT);
    exp_addr = '0;
    cur_dir = 1'b0;
    cur_word = '0;
    byte_idx = 1'b0;
    exp_byte = '0;
    samples_seen = 0;
    cycle = 0;
    last_cycle = 0;
    have_last = 1'b0;
    timing_on = 1'b0;
    quiet = 1'b0;
    rng = 32'ha8e9;
    frng = xorshift(32'ha8e9 ^ 32'h1357_9bdf);
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    play_words(6);  // Forward from 0
    pause_playback();
    send_key(KEY_BACK);
    play_words(10);  // Backward through 0
    pause_playback();

    send_key(KEY_RESTART);  // Backward restart to ADDR_LAST
    send_key(KEY_FWD);
    play_words(4);  // Forward wrap to 0
    pause_playback();
    send_key(KEY_RESTART);
    play_words(3);
    pause_playback();

    repeat (300) send_speed(1'b1, 1'b0, 1'b0);  // Past the lower clamp
    settle_rate();
    play_words(4);
    pause_playback();
    repeat (300) send_speed(1'b0, 1'b1, 1'b0);  // Past the upper clamp
    settle_rate();
    play_words(3);
    pause_playback();
    repeat (40) begin
      rng = xorshift(rng);
      send_speed(rng[0], rng[1], rng[2] & rng[3]);
    end
    settle_rate();
    play_words(4);
    pause_playback();

    repeat (12) begin
      rng = xorshift(rng);
      repeat (1 + rng % 4) begin
        rng = xorshift(rng);
        send_key(random_code(rng));
      end
      rng = xorshift(rng);
      repeat (rng % 4) begin
        rng = xorshift(rng);
        send_speed(rng[0], rng[1], rng[2] & rng[3] & rng[4]);
      end
      settle_rate();
      rng = xorshift(rng);
      play_words(1 + rng % 4);
      pause_playback();
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: hw/audio_player_top.sv
`timescale 1ns/1ps

module audio_player_top import player_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                key_valid,
  input  logic [7:0]          key_code,
  input  logic                speed_up,
  input  logic                speed_down,
  input  logic                speed_reset,
  input  logic                flash_waitrequest,
  input  logic [WORD_W-1:0]   flash_readdata,
  input  logic                flash_readdatavalid,
  output flash_req_t          flash_req,
  output logic [SAMPLE_W-1:0] sample,
  output logic                sample_valid
);

  play_cmd_t cmd;
  fetch_t    fetch;
  logic      restart_ack;
  logic      tick;
  logic      word_done;

  // ========================================
  // Command and rate
  // ========================================
  key_decode u_key_decode (
    .clk, .rst, .key_valid, .key_code, .restart_ack,
    .cmd
  );

  rate_gen u_rate_gen (
    .clk, .rst, .speed_up, .speed_down, .speed_reset,
    .tick
  );

  // ========================================
  // Fetch and playout
  // ========================================
  flash_reader u_flash_reader (
    .clk, .rst, .cmd,
    .flash_waitrequest, .flash_readdatavalid, .flash_readdata,
    .word_done,
    .flash_req, .fetch, .restart_ack
  );

  sample_out u_sample_out (
    .clk, .rst, .tick, .fetch,
    .sample, .sample_valid, .word_done
  );

endmodule

// File: hw/sample_out.sv
`timescale 1ns/1ps

module sample_out import player_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                tick,
  input  fetch_t              fetch,
  output logic [SAMPLE_W-1:0] sample,
  output logic                sample_valid,
  output logic                word_done
);

  logic [SAMPLE_W-1:0] byte_lo;  // Bits 15:8
  logic [SAMPLE_W-1:0] byte_hi;  // Bits 31:24
  logic                dir_q;
  logic                full;
  logic                idx;      // 0 = first byte out next

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (fetch.valid) begin
      byte_lo <= fetch.word[15:8];
      byte_hi <= fetch.word[31:24];
      dir_q   <= fetch.dir;
    end
    if (tick && full) begin
      // Backward plays the high byte first
      sample <= (idx ^ dir_q) ? byte_hi : byte_lo;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      full         <= 1'b0;
      idx          <= 1'b0;
      sample_valid <= 1'b0;
      word_done    <= 1'b0;
    end else begin
      sample_valid <= tick && full;
      word_done    <= tick && full && idx;
      if (fetch.valid) begin
        full <= 1'b1;
        idx  <= 1'b0;
      end else if (tick && full) begin
        idx <= ~idx;
        if (idx) full <= 1'b0;  // Second byte out, release
      end
    end
  end

  a_no_overrun : assert property (
    @(posedge clk) disable iff (rst)
    fetch.valid |-> !full
  ) else $error("new word fetched while previous still held");

endmodule

// File: hw/flash_reader.sv
`timescale 1ns/1ps

module flash_reader import player_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  play_cmd_t         cmd,
  input  logic              flash_waitrequest,
  input  logic              flash_readdatavalid,
  input  logic [WORD_W-1:0] flash_readdata,
  input  logic              word_done,
  output flash_req_t        flash_req,
  output fetch_t            fetch,
  output logic              restart_ack
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT_DATA, S_WAIT_DONE} state_t;

  state_t state;
  logic   dir_q;  // Direction of the word in flight

  // Wraps between 0 and ADDR_LAST
  function automatic logic [ADDR_W-1:0] step_addr(input logic [ADDR_W-1:0] a,
                                                  input logic back);
    if (back) return (a == '0) ? ADDR_LAST : a - 1'b1;
    return (a == ADDR_LAST) ? '0 : a + 1'b1;
  endfunction

  // ========================================
  // Read sequencer
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= S_IDLE;
      flash_req.read <= 1'b0;
      flash_req.addr <= '0;
      dir_q          <= 1'b0;
      fetch.valid    <= 1'b0;
      restart_ack    <= 1'b0;
    end else begin
      fetch.valid <= 1'b0;
      restart_ack <= 1'b0;
      case (state)
        S_IDLE: begin
          if (cmd.play) begin
            flash_req.read <= 1'b1;
            dir_q          <= cmd.dir;
            state          <= S_REQ;
          end else if (cmd.restart && !restart_ack) begin  // Skip while last ack in flight
            flash_req.addr <= cmd.dir ? ADDR_LAST : '0;
            restart_ack    <= 1'b1;
          end
        end
        S_REQ: begin
          if (!flash_waitrequest) begin  // Accepted this cycle
            flash_req.read <= 1'b0;
            state          <= S_WAIT_DATA;
          end
        end
        S_WAIT_DATA: begin
          if (flash_readdatavalid) begin
            fetch.valid <= 1'b1;
            fetch.word  <= flash_readdata;
            fetch.dir   <= dir_q;
            state       <= S_WAIT_DONE;
          end
        end
        S_WAIT_DONE: begin
          if (word_done) begin
            if (cmd.restart) begin
              flash_req.addr <= cmd.dir ? ADDR_LAST : '0;
              restart_ack    <= 1'b1;
            end else begin
              flash_req.addr <= step_addr(flash_req.addr, dir_q);
            end
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_req_stable : assert property (
    @(posedge clk) disable iff (rst)
    flash_req.read && flash_waitrequest |=> flash_req.read && $stable(flash_req.addr)
  ) else $error("flash request changed under waitrequest");

endmodule

// File: hw/rate_gen.sv
`timescale 1ns/1ps

module rate_gen import player_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic speed_up,
  input  logic speed_down,
  input  logic speed_reset,
  output logic tick
);

  logic [RATE_W-1:0] period;
  logic [RATE_W-1:0] cnt;

  // ========================================
  // Speed register
  // ========================================
  always_ff @(posedge clk) begin
    if (rst || speed_reset) begin
      period <= RATE_DEFAULT;
    end else if (speed_up) begin  // Shorter period, faster
      if (period < RATE_MIN + RATE_STEP) period <= RATE_MIN;
      else                               period <= period - RATE_STEP;
    end else if (speed_down) begin
      if (period > RATE_MAX - RATE_STEP) period <= RATE_MAX;
      else                               period <= period + RATE_STEP;
    end
  end

  // Down-counter, new period picked up only at wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= RATE_DEFAULT - 1'b1;
      tick <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= period - 1'b1;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

  a_period_clamped : assert property (
    @(posedge clk) disable iff (rst)
    period >= RATE_MIN && period <= RATE_MAX
  ) else $error("sample period out of range: %0d", period);

endmodule

// File: hw/key_decode.sv
`timescale 1ns/1ps

module key_decode import player_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       key_valid,
  input  logic [7:0] key_code,
  input  logic       restart_ack,
  output play_cmd_t  cmd
);

  logic play_q;
  logic dir_q;
  logic restart_q;

  // ========================================
  // Play and direction levels
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      play_q <= 1'b0;  // Paused
      dir_q  <= 1'b0;  // Forward
    end else if (key_valid) begin
      case (key_code)
        KEY_PLAY:  play_q <= 1'b1;
        KEY_PAUSE: play_q <= 1'b0;
        KEY_FWD:   dir_q  <= 1'b0;
        KEY_BACK:  dir_q  <= 1'b1;
        default: begin
          // Anything else is not a command
        end
      endcase
    end
  end

  // ========================================
  // Restart request
  // ========================================
  // Held until the reader has applied it. A fresh R in the
  // same cycle as the ack keeps the flag set.
  always_ff @(posedge clk) begin
    if (rst) begin
      restart_q <= 1'b0;
    end else if (key_valid && key_code == KEY_RESTART) begin
      restart_q <= 1'b1;
    end else if (restart_ack) begin
      restart_q <= 1'b0;  // Consumed
    end
  end

  assign cmd.play    = play_q;
  assign cmd.dir     = dir_q;
  assign cmd.restart = restart_q;

  // Reader only acknowledges a restart that is pending
  a_ack_needs_restart : assert property (
    @(posedge clk) disable iff (rst)
    restart_ack |-> cmd.restart
  ) else $error("restart_ack without pending restart");

endmodule

// File: hw/player_pkg.sv
package player_pkg;

  // ========================================
  // Command codes, ASCII
  // ========================================
  localparam logic [7:0] KEY_PLAY    = 8'h45;  // E
  localparam logic [7:0] KEY_PAUSE   = 8'h44;  // D
  localparam logic [7:0] KEY_FWD     = 8'h46;  // F
  localparam logic [7:0] KEY_BACK    = 8'h42;  // B
  localparam logic [7:0] KEY_RESTART = 8'h52;  // R

  // ========================================
  // Widths and sample region
  // ========================================
  localparam int ADDR_W   = 23;
  localparam int WORD_W   = 32;
  localparam int SAMPLE_W = 8;
  localparam int RATE_W   = 16;

  localparam logic [ADDR_W-1:0] ADDR_LAST = 23'h7FFFF;  // Last word of samples

  // Sample period in clocks
  localparam logic [RATE_W-1:0] RATE_DEFAULT = 16'd1136;
  localparam logic [RATE_W-1:0] RATE_STEP    = 16'd15;
  localparam logic [RATE_W-1:0] RATE_MIN     = 16'd64;
  localparam logic [RATE_W-1:0] RATE_MAX     = 16'd4000;

  // ========================================
  // Shared structs
  // ========================================
  typedef struct packed {
    logic play;
    logic dir;      // 1 = backward
    logic restart;
  } play_cmd_t;

  typedef struct packed {
    logic              valid;
    logic              dir;
    logic [WORD_W-1:0] word;
  } fetch_t;

  typedef struct packed {
    logic              read;
    logic [ADDR_W-1:0] addr;
  } flash_req_t;

endpackage
